//--- source/bus_pkg.sv
`default_nettype none

package bus_pkg;

  // Bus widths
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int RESP_W = 2;

  // Response codes
  localparam logic [RESP_W-1:0] RESP_OKAY   = 2'd0;
  localparam logic [RESP_W-1:0] RESP_SLVERR = 2'd2;

  ////////////////////
  // Register map
  ////////////////////

  // LED register, read and write
  localparam logic [ADDR_W-1:0] ADDR_LED       = 32'h0000_0000;
  // Synchronized switches, read only
  localparam logic [ADDR_W-1:0] ADDR_SW        = 32'h0000_0004;
  // Microsecond count, read only
  localparam logic [ADDR_W-1:0] ADDR_TIMER     = 32'h0000_0008;
  // Write sends a byte, read pops one
  localparam logic [ADDR_W-1:0] ADDR_UART_DATA = 32'h0000_000C;
  // FIFO and transmitter state, read only
  localparam logic [ADDR_W-1:0] ADDR_UART_STAT = 32'h0000_0010;

endpackage

`default_nettype wire

//--- source/periph_pkg.sv
`default_nettype none

package periph_pkg;

  // GPIO
  localparam int NUM_LEDS     = 4;
  localparam int NUM_SWITCHES = 4;

  // Timer prescale is small so simulations stay short
  localparam int TICKS_PER_US = 10;
  localparam int TIMER_W      = 32;

  ////////////////////
  // UART
  ////////////////////

  localparam int CLKS_PER_BIT = 16;
  localparam int BYTE_W       = 8;
  localparam int FIFO_DEPTH   = 8;

  // Status register bits
  localparam int STAT_NOT_EMPTY = 0;
  localparam int STAT_TX_BUSY   = 1;

  // Set in a data register read that popped a byte
  localparam int RX_VALID_BIT = 8;

endpackage

`default_nettype wire

//--- source/axil_slave_port.sv
`timescale 1ns/1ps
`default_nettype none

module axil_slave_port (
  input  logic                                clk,
  input  logic                                rst,
  input  logic [bus_pkg::ADDR_W-1:0]          i_awaddr,
  input  logic                                i_awvalid,
  output logic                                o_awready,
  input  logic [bus_pkg::DATA_W-1:0]          i_wdata,
  input  logic                                i_wvalid,
  output logic                                o_wready,
  output logic                                o_bvalid,
  output logic [bus_pkg::RESP_W-1:0]          o_bresp,
  input  logic                                i_bready,
  input  logic [bus_pkg::ADDR_W-1:0]          i_araddr,
  input  logic                                i_arvalid,
  output logic                                o_arready,
  output logic                                o_rvalid,
  output logic [bus_pkg::DATA_W-1:0]          o_rdata,
  output logic [bus_pkg::RESP_W-1:0]          o_rresp,
  input  logic                                i_rready,
  input  logic [periph_pkg::NUM_LEDS-1:0]     i_led,
  input  logic [periph_pkg::NUM_SWITCHES-1:0] i_sw_sync,
  input  logic [periph_pkg::TIMER_W-1:0]      i_timer_count,
  input  logic                                i_tx_busy,
  input  logic                                i_fifo_empty,
  input  logic [periph_pkg::BYTE_W-1:0]       i_fifo_byte,
  output logic                                o_led_we,
  output logic [periph_pkg::NUM_LEDS-1:0]     o_led_wdata,
  output logic                                o_tx_start,
  output logic [periph_pkg::BYTE_W-1:0]       o_tx_byte,
  output logic                                o_fifo_pop
);
  import bus_pkg::*;
  import periph_pkg::*;

  logic              ar_accept;
  logic              aw_accept;
  logic              wr_to_led;
  logic              wr_to_uart;
  logic              rd_mapped;
  logic [DATA_W-1:0] rd_word;

  ////////////////////
  // Acceptance
  ////////////////////

  assign wr_to_led  = (i_awaddr == ADDR_LED);
  assign wr_to_uart = (i_awaddr == ADDR_UART_DATA);

  // A read wins a tie with a write
  assign ar_accept = i_arvalid && !o_rvalid && !o_bvalid;

  // Hold UART writes back until the transmitter is free
  assign aw_accept = i_awvalid && i_wvalid && !o_bvalid && !o_rvalid && !ar_accept &&
                     !(wr_to_uart && i_tx_busy);

  assign o_arready = ar_accept;
  assign o_awready = aw_accept;
  assign o_wready  = aw_accept;

  // Strobes to the peripherals
  assign o_led_we    = aw_accept && wr_to_led;
  assign o_led_wdata = i_wdata[NUM_LEDS-1:0];
  assign o_tx_start  = aw_accept && wr_to_uart;
  assign o_tx_byte   = i_wdata[BYTE_W-1:0];
  assign o_fifo_pop  = ar_accept && (i_araddr == ADDR_UART_DATA) && !i_fifo_empty;

  ////////////////////
  // Read select
  ////////////////////

  always_comb begin
    rd_word   = '0;
    rd_mapped = 1'b1;
    case (i_araddr)
      ADDR_LED:   rd_word = DATA_W'(i_led);
      ADDR_SW:    rd_word = DATA_W'(i_sw_sync);
      ADDR_TIMER: rd_word = DATA_W'(i_timer_count);
      ADDR_UART_DATA: begin
        if (!i_fifo_empty) begin
          rd_word[BYTE_W-1:0]   = i_fifo_byte;
          rd_word[RX_VALID_BIT] = 1'b1;
        end
      end
      ADDR_UART_STAT: begin
        rd_word[STAT_NOT_EMPTY] = !i_fifo_empty;
        rd_word[STAT_TX_BUSY]   = i_tx_busy;
      end
      default: rd_mapped = 1'b0;
    endcase
  end

  ////////////////////
  // Responses
  ////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      o_bvalid <= 1'b0;
    end else if (aw_accept) begin
      o_bvalid <= 1'b1;
    end else if (i_bready) begin
      o_bvalid <= 1'b0;
    end
  end

  // Only LED and UART data take writes
  always_ff @(posedge clk) begin
    if (aw_accept) begin
      o_bresp <= (wr_to_led || wr_to_uart) ? RESP_OKAY : RESP_SLVERR;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      o_rvalid <= 1'b0;
    end else if (ar_accept) begin
      o_rvalid <= 1'b1;
    end else if (i_rready) begin
      o_rvalid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (ar_accept) begin
      o_rdata <= rd_word;
      o_rresp <= rd_mapped ? RESP_OKAY : RESP_SLVERR;
    end
  end

endmodule

`default_nettype wire

//--- source/sys_regs.sv
`timescale 1ns/1ps
`default_nettype none

module sys_regs (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                i_led_we,
  input  logic [periph_pkg::NUM_LEDS-1:0]     i_led_wdata,
  input  logic [periph_pkg::NUM_SWITCHES-1:0] i_sw,
  output logic [periph_pkg::NUM_LEDS-1:0]     o_led,
  output logic [periph_pkg::NUM_SWITCHES-1:0] o_sw_sync,
  output logic [periph_pkg::TIMER_W-1:0]      o_timer_count
);
  import periph_pkg::*;

  localparam int PRESCALE_W = $clog2(TICKS_PER_US);

  logic [NUM_SWITCHES-1:0] sw_meta;
  logic [PRESCALE_W-1:0]   prescale;

  always_ff @(posedge clk) begin
    if (rst) begin
      o_led <= '0;
    end else if (i_led_we) begin
      o_led <= i_led_wdata;
    end
  end

  // Two-flop switch synchronizer
  always_ff @(posedge clk) begin
    if (rst) begin
      sw_meta   <= '0;
      o_sw_sync <= '0;
    end else begin
      sw_meta   <= i_sw;
      o_sw_sync <= sw_meta;
    end
  end

  // Prescaler wraps once per microsecond
  always_ff @(posedge clk) begin
    if (rst) begin
      prescale      <= '0;
      o_timer_count <= '0;
    end else if (prescale == PRESCALE_W'(TICKS_PER_US - 1)) begin
      prescale      <= '0;
      o_timer_count <= o_timer_count + 1'b1;
    end else begin
      prescale <= prescale + 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- source/uart_tx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tx #(
  parameter int CLKS_PER_BIT = periph_pkg::CLKS_PER_BIT
) (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          i_start,
  input  logic [periph_pkg::BYTE_W-1:0] i_byte,
  output logic                          o_busy,
  output logic                          o_serial
);
  import periph_pkg::*;

  localparam int CNT_W = $clog2(CLKS_PER_BIT);
  localparam int BIT_W = $clog2(BYTE_W);

  typedef enum logic [2:0] {
    S_IDLE,
    S_START,
    S_DATA,
    S_STOP,
    S_CLEANUP
  } tx_state_t;

  tx_state_t         state;
  logic [CNT_W-1:0]  clk_cnt;
  logic [BIT_W-1:0]  bit_cnt;
  logic [BYTE_W-1:0] shift;
  logic              bit_done;

  assign bit_done = (clk_cnt == CNT_W'(CLKS_PER_BIT - 1));
  assign o_busy   = (state != S_IDLE);

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= S_IDLE;
      clk_cnt <= '0;
      bit_cnt <= '0;
    end else begin
      case (state)
        S_IDLE: begin
          clk_cnt <= '0;
          bit_cnt <= '0;
          if (i_start) begin
            state <= S_START;
          end
        end
        S_START: begin
          if (bit_done) begin
            clk_cnt <= '0;
            state   <= S_DATA;
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        S_DATA: begin
          if (bit_done) begin
            clk_cnt <= '0;
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == BIT_W'(BYTE_W - 1)) begin
              state <= S_STOP;
            end
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        S_STOP: begin
          if (bit_done) begin
            clk_cnt <= '0;
            state   <= S_CLEANUP;
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        default: state <= S_IDLE;  // cleanup lasts one cycle
      endcase
    end
  end

  // LSB goes out first
  always_ff @(posedge clk) begin
    if (state == S_IDLE && i_start) begin
      shift <= i_byte;
    end else if (state == S_DATA && bit_done) begin
      shift <= {1'b0, shift[BYTE_W-1:1]};
    end
  end

  // Line follows the state one cycle later
  always_ff @(posedge clk) begin
    if (rst) begin
      o_serial <= 1'b1;
    end else begin
      case (state)
        S_START: o_serial <= 1'b0;
        S_DATA:  o_serial <= shift[0];
        default: o_serial <= 1'b1;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- source/uart_rx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_rx #(
  parameter int CLKS_PER_BIT = periph_pkg::CLKS_PER_BIT
) (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          i_serial,
  output logic                          o_valid,
  output logic [periph_pkg::BYTE_W-1:0] o_byte
);
  import periph_pkg::*;

  localparam int CNT_W = $clog2(CLKS_PER_BIT);
  localparam int BIT_W = $clog2(BYTE_W);

  typedef enum logic [1:0] {
    S_IDLE,
    S_START,
    S_DATA,
    S_STOP
  } rx_state_t;

  rx_state_t        state;
  logic             serial_meta;
  logic             serial_sync;
  logic [CNT_W-1:0] clk_cnt;
  logic [BIT_W-1:0] bit_cnt;
  logic             bit_done;
  logic             half_done;

  assign bit_done  = (clk_cnt == CNT_W'(CLKS_PER_BIT - 1));
  assign half_done = (clk_cnt == CNT_W'((CLKS_PER_BIT - 1) / 2));

  // Line idles high
  always_ff @(posedge clk) begin
    if (rst) begin
      serial_meta <= 1'b1;
      serial_sync <= 1'b1;
    end else begin
      serial_meta <= i_serial;
      serial_sync <= serial_meta;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= S_IDLE;
      clk_cnt <= '0;
      bit_cnt <= '0;
      o_valid <= 1'b0;
    end else begin
      o_valid <= 1'b0;
      case (state)
        S_IDLE: begin
          clk_cnt <= '0;
          bit_cnt <= '0;
          if (!serial_sync) begin
            state <= S_START;
          end
        end
        // Still low at mid-bit means a real start bit
        S_START: begin
          if (half_done) begin
            clk_cnt <= '0;
            state   <= serial_sync ? S_IDLE : S_DATA;
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        S_DATA: begin
          if (bit_done) begin
            clk_cnt <= '0;
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == BIT_W'(BYTE_W - 1)) begin
              state <= S_STOP;
            end
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        S_STOP: begin
          if (bit_done) begin
            clk_cnt <= '0;
            o_valid <= serial_sync;
            state   <= S_IDLE;
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == S_DATA && bit_done) begin
      o_byte <= {serial_sync, o_byte[BYTE_W-1:1]};
    end
  end

endmodule

`default_nettype wire

//--- source/rx_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module rx_fifo #(
  parameter int DEPTH = periph_pkg::FIFO_DEPTH
) (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          i_push,
  input  logic [periph_pkg::BYTE_W-1:0] i_push_byte,
  input  logic                          i_pop,
  output logic                          o_empty,
  output logic [periph_pkg::BYTE_W-1:0] o_head_byte
);
  import periph_pkg::*;

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [BYTE_W-1:0] mem [DEPTH];
  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;
  logic [CNT_W-1:0]  count;
  logic              full;
  logic              do_push;
  logic              do_pop;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign full        = (count == CNT_W'(DEPTH));
  assign o_empty     = (count == '0);
  assign do_push     = i_push && !full;  // bytes arriving when full are lost
  assign do_pop      = i_pop && !o_empty;
  assign o_head_byte = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= i_push_byte;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (do_pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- source/periph_top.sv
`timescale 1ns/1ps
`default_nettype none

module periph_top (
  input  logic                                clk,
  input  logic                                rst,
  input  logic [bus_pkg::ADDR_W-1:0]          i_awaddr,
  input  logic                                i_awvalid,
  output logic                                o_awready,
  input  logic [bus_pkg::DATA_W-1:0]          i_wdata,
  input  logic                                i_wvalid,
  output logic                                o_wready,
  output logic                                o_bvalid,
  output logic [bus_pkg::RESP_W-1:0]          o_bresp,
  input  logic                                i_bready,
  input  logic [bus_pkg::ADDR_W-1:0]          i_araddr,
  input  logic                                i_arvalid,
  output logic                                o_arready,
  output logic                                o_rvalid,
  output logic [bus_pkg::DATA_W-1:0]          o_rdata,
  output logic [bus_pkg::RESP_W-1:0]          o_rresp,
  input  logic                                i_rready,
  input  logic [periph_pkg::NUM_SWITCHES-1:0] i_sw,
  output logic [periph_pkg::NUM_LEDS-1:0]     o_led,
  input  logic                                i_uart_rx,
  output logic                                o_uart_tx
);
  import periph_pkg::*;

  logic                    led_we;
  logic [NUM_LEDS-1:0]     led_wdata;
  logic [NUM_SWITCHES-1:0] sw_sync;
  logic [TIMER_W-1:0]      timer_count;
  logic                    tx_start;
  logic [BYTE_W-1:0]       tx_byte;
  logic                    tx_busy;
  logic                    fifo_pop;
  logic                    fifo_empty;
  logic [BYTE_W-1:0]       fifo_byte;
  logic                    rx_valid;
  logic [BYTE_W-1:0]       rx_byte;

  axil_slave_port port0 (
    .clk           (clk),
    .rst           (rst),
    .i_awaddr      (i_awaddr),
    .i_awvalid     (i_awvalid),
    .o_awready     (o_awready),
    .i_wdata       (i_wdata),
    .i_wvalid      (i_wvalid),
    .o_wready      (o_wready),
    .o_bvalid      (o_bvalid),
    .o_bresp       (o_bresp),
    .i_bready      (i_bready),
    .i_araddr      (i_araddr),
    .i_arvalid     (i_arvalid),
    .o_arready     (o_arready),
    .o_rvalid      (o_rvalid),
    .o_rdata       (o_rdata),
    .o_rresp       (o_rresp),
    .i_rready      (i_rready),
    .i_led         (o_led),
    .i_sw_sync     (sw_sync),
    .i_timer_count (timer_count),
    .i_tx_busy     (tx_busy),
    .i_fifo_empty  (fifo_empty),
    .i_fifo_byte   (fifo_byte),
    .o_led_we      (led_we),
    .o_led_wdata   (led_wdata),
    .o_tx_start    (tx_start),
    .o_tx_byte     (tx_byte),
    .o_fifo_pop    (fifo_pop)
  );

  sys_regs regs0 (
    .clk           (clk),
    .rst           (rst),
    .i_led_we      (led_we),
    .i_led_wdata   (led_wdata),
    .i_sw          (i_sw),
    .o_led         (o_led),
    .o_sw_sync     (sw_sync),
    .o_timer_count (timer_count)
  );

  ////////////////////
  // UART
  ////////////////////

  uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) tx0 (
    .clk      (clk),
    .rst      (rst),
    .i_start  (tx_start),
    .i_byte   (tx_byte),
    .o_busy   (tx_busy),
    .o_serial (o_uart_tx)
  );

  uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) rx0 (
    .clk      (clk),
    .rst      (rst),
    .i_serial (i_uart_rx),
    .o_valid  (rx_valid),
    .o_byte   (rx_byte)
  );

  rx_fifo #(.DEPTH(FIFO_DEPTH)) fifo0 (
    .clk         (clk),
    .rst         (rst),
    .i_push      (rx_valid),
    .i_push_byte (rx_byte),
    .i_pop       (fifo_pop),
    .o_empty     (fifo_empty),
    .o_head_byte (fifo_byte)
  );

endmodule

`default_nettype wire

//--- verification/periph_tb.sv
`timescale 1ns/1ps
`default_nettype none

module periph_tb;
  import bus_pkg::*;
  import periph_pkg::*;

  localparam int WAIT_LIMIT     = 2000;
  localparam int POLL_LIMIT     = 500;
  localparam int NUM_UART_BYTES = 5;
  localparam int TIMER_GAP      = 200;

  logic                    clk;
  logic                    rst;
  logic [ADDR_W-1:0]       awaddr;
  logic                    awvalid;
  logic                    awready;
  logic [DATA_W-1:0]       wdata;
  logic                    wvalid;
  logic                    wready;
  logic                    bvalid;
  logic [RESP_W-1:0]       bresp;
  logic                    bready;
  logic [ADDR_W-1:0]       araddr;
  logic                    arvalid;
  logic                    arready;
  logic                    rvalid;
  logic [DATA_W-1:0]       rdata;
  logic [RESP_W-1:0]       rresp;
  logic                    rready;
  logic [NUM_SWITCHES-1:0] sw;
  logic [NUM_LEDS-1:0]     led;
  logic                    uart_line;

  string             test_name;
  logic [15:0]       lfsr_state;
  logic [BYTE_W-1:0] sent_bytes [$];

  // Serial output loops straight back into the receiver
  periph_top dut0 (
    .clk       (clk),
    .rst       (rst),
    .i_awaddr  (awaddr),
    .i_awvalid (awvalid),
    .o_awready (awready),
    .i_wdata   (wdata),
    .i_wvalid  (wvalid),
    .o_wready  (wready),
    .o_bvalid  (bvalid),
    .o_bresp   (bresp),
    .i_bready  (bready),
    .i_araddr  (araddr),
    .i_arvalid (arvalid),
    .o_arready (arready),
    .o_rvalid  (rvalid),
    .o_rdata   (rdata),
    .o_rresp   (rresp),
    .i_rready  (rready),
    .i_sw      (sw),
    .o_led     (led),
    .i_uart_rx (uart_line),
    .o_uart_tx (uart_line)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #4 clk = ~clk;
    end
  end

  ////////////////////
  // Checking
  ////////////////////

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("RESULT: FAIL");
    $fatal(1);
  endtask

  task automatic check_value(input string what, input logic [DATA_W-1:0] expected,
                             input logic [DATA_W-1:0] actual);
    assert (actual === expected)
      else stop_run($sformatf("FAIL %s %s: expected 0x%0h, actual 0x%0h",
                              test_name, what, expected, actual));
  endtask

  // Taps at 16, 14, 13 and 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] state);
    return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
  endfunction

  task automatic draw_byte(output logic [BYTE_W-1:0] value);
    value = '0;
    for (int i = 0; i < BYTE_W; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      value      = {value[BYTE_W-2:0], lfsr_state[0]};
    end
  endtask

  ////////////////////
  // Bus master
  ////////////////////

  task automatic idle_cycles(input int count);
    repeat (count) @(posedge clk);
  endtask

  // Keeps bready low for hold_cycles once bvalid is up
  task automatic write_reg(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                           input int hold_cycles, output logic [RESP_W-1:0] resp);
    int waited;
    awaddr  <= addr;
    awvalid <= 1'b1;
    wdata   <= data;
    wvalid  <= 1'b1;
    waited = 0;
    @(posedge clk);
    while (!(awready && wready)) begin
      waited++;
      if (waited == WAIT_LIMIT) begin
        stop_run("Timed out waiting for the write address and data to be accepted");
      end
      @(posedge clk);
    end
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    waited = 0;
    @(posedge clk);
    while (!bvalid) begin
      waited++;
      if (waited == WAIT_LIMIT) begin
        stop_run("Timed out waiting for the write response");
      end
      @(posedge clk);
    end
    for (int i = 0; i < hold_cycles; i++) begin
      @(posedge clk);
      check_value("bvalid while bready low", 32'd1, DATA_W'(bvalid));
    end
    bready <= 1'b1;
    @(posedge clk);
    check_value("bvalid at handshake", 32'd1, DATA_W'(bvalid));
    resp = bresp;
    bready <= 1'b0;
  endtask

  task automatic read_reg(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data,
                          output logic [RESP_W-1:0] resp);
    int waited;
    araddr  <= addr;
    arvalid <= 1'b1;
    waited = 0;
    @(posedge clk);
    while (!arready) begin
      waited++;
      if (waited == WAIT_LIMIT) begin
        stop_run("Timed out waiting for the read address to be accepted");
      end
      @(posedge clk);
    end
    arvalid <= 1'b0;
    rready  <= 1'b1;
    waited = 0;
    @(posedge clk);
    while (!rvalid) begin
      waited++;
      if (waited == WAIT_LIMIT) begin
        stop_run("Timed out waiting for the read data");
      end
      @(posedge clk);
    end
    data = rdata;
    resp = rresp;
    rready <= 1'b0;
  endtask

  task automatic wait_rx_byte();
    logic [DATA_W-1:0] stat;
    logic [RESP_W-1:0] resp;
    int                polls;
    polls = 0;
    read_reg(ADDR_UART_STAT, stat, resp);
    while (!stat[STAT_NOT_EMPTY]) begin
      polls++;
      if (polls == POLL_LIMIT) begin
        stop_run("Timed out polling the UART status for a received byte");
      end
      read_reg(ADDR_UART_STAT, stat, resp);
    end
  endtask

  ////////////////////
  // Test sequence
  ////////////////////

  initial begin
    logic [DATA_W-1:0] data;
    logic [DATA_W-1:0] t_first;
    logic [DATA_W-1:0] t_second;
    logic [DATA_W-1:0] expected;
    logic [RESP_W-1:0] resp;
    logic [BYTE_W-1:0] tx_value;
    int                elapsed_us;
    int                expected_us;
    lfsr_state = 16'd3;
    test_name  = "reset";
    rst     <= 1'b1;
    awaddr  <= '0;
    awvalid <= 1'b0;
    wdata   <= '0;
    wvalid  <= 1'b0;
    bready  <= 1'b0;
    araddr  <= '0;
    arvalid <= 1'b0;
    rready  <= 1'b0;
    sw      <= '0;
    repeat (8) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    check_value("led", 32'd0, DATA_W'(led));
    check_value("serial line idle", 32'd1, DATA_W'(uart_line));

    // Only the low LED bits are kept
    test_name = "gpio";
    write_reg(ADDR_LED, 32'h0000_005A, 0, resp);
    check_value("led write resp", DATA_W'(RESP_OKAY), DATA_W'(resp));
    check_value("led pins", 32'h0000_000A, DATA_W'(led));
    read_reg(ADDR_LED, data, resp);
    check_value("led readback", 32'h0000_000A, data);
    check_value("led read resp", DATA_W'(RESP_OKAY), DATA_W'(resp));
    sw <= 4'h6;
    idle_cycles(4);
    read_reg(ADDR_SW, data, resp);
    check_value("switches", 32'h0000_0006, data);
    check_value("switch read resp", DATA_W'(RESP_OKAY), DATA_W'(resp));

    test_name = "responses";
    read_reg(32'h0000_0040, data, resp);
    check_value("unmapped read resp", DATA_W'(RESP_SLVERR), DATA_W'(resp));
    write_reg(ADDR_TIMER, 32'h0000_1234, 0, resp);
    check_value("timer write resp", DATA_W'(RESP_SLVERR), DATA_W'(resp));
    write_reg(ADDR_LED, 32'h0000_0003, 6, resp);
    check_value("held write resp", DATA_W'(RESP_OKAY), DATA_W'(resp));
    check_value("led pins", 32'h0000_0003, DATA_W'(led));

    test_name = "timer";
    read_reg(ADDR_TIMER, t_first, resp);
    check_value("timer read resp", DATA_W'(RESP_OKAY), DATA_W'(resp));
    idle_cycles(TIMER_GAP);
    read_reg(ADDR_TIMER, t_second, resp);
    elapsed_us  = int'(t_second - t_first);
    expected_us = TIMER_GAP / TICKS_PER_US;
    assert (elapsed_us >= expected_us - 1 && elapsed_us <= expected_us + 1)
      else stop_run($sformatf("FAIL %s elapsed us: expected %0d +/- 1, actual %0d",
                              test_name, expected_us, elapsed_us));

    // Back-pressure spaces these writes one frame apart
    test_name = "uart loopback";
    for (int i = 0; i < NUM_UART_BYTES; i++) begin
      draw_byte(tx_value);
      sent_bytes.push_back(tx_value);
      write_reg(ADDR_UART_DATA, DATA_W'(tx_value), 0, resp);
      check_value("data write resp", DATA_W'(RESP_OKAY), DATA_W'(resp));
    end
    while (sent_bytes.size() > 0) begin
      wait_rx_byte();
      read_reg(ADDR_UART_DATA, data, resp);
      expected = DATA_W'(sent_bytes.pop_front()) | (32'd1 << RX_VALID_BIT);
      check_value("received byte", expected, data);
      check_value("data read resp", DATA_W'(RESP_OKAY), DATA_W'(resp));
    end

    test_name = "uart empty";
    read_reg(ADDR_UART_DATA, data, resp);
    check_value("valid flag", 32'd0, DATA_W'(data[RX_VALID_BIT]));
    read_reg(ADDR_UART_STAT, data, resp);
    check_value("not-empty flag", 32'd0, DATA_W'(data[STAT_NOT_EMPTY]));

    test_name = "uart busy";
    draw_byte(tx_value);
    write_reg(ADDR_UART_DATA, DATA_W'(tx_value), 0, resp);
    read_reg(ADDR_UART_STAT, data, resp);
    check_value("tx busy flag", 32'd1, DATA_W'(data[STAT_TX_BUSY]));
    wait_rx_byte();
    read_reg(ADDR_UART_DATA, data, resp);
    expected = DATA_W'(tx_value) | (32'd1 << RX_VALID_BIT);
    check_value("received byte", expected, data);

    $display("RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

//--- periph_bus.f
source/bus_pkg.sv
source/periph_pkg.sv
source/axil_slave_port.sv
source/sys_regs.sv
source/uart_tx.sv
source/uart_rx.sv
source/rx_fifo.sv
source/periph_top.sv
verification/periph_tb.sv

//--- Makefile
TOP = periph_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f periph_bus.f --top-module $(TOP)

# Passes only when the pass message shows up in the simulation output
run: compile
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "RESULT: PASS"

clean:
	rm -rf obj_dir
